//--- project.f
logic/mshr_pkg.sv
logic/mshr_entry_pool.sv
logic/mshr_head_table.sv
logic/mshr_ctrl.sv
logic/dcache_mshr.sv
tests/dcache_mshr_assertions.sv
tests/tb_dcache_mshr.sv

//--- Makefile
# Verilator build and run of the MSHR testbench; every variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= tb_dcache_mshr
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"

test:
	@mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_dcache_mshr.sv
// Random traffic from a fixed LFSR seed over eight blocks; the run stops at the first mismatch

`timescale 1ns/1ps

module tb_dcache_mshr;

    localparam int unsigned NUM_WRITES     = 400;
    localparam int unsigned TIMEOUT_CYCLES = NUM_WRITES * 60;
    localparam logic [31:0] SEED           = 32'h1af0_c980;
    // Eight neighbouring blocks keep merges frequent
    localparam logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] BLOCK_BASE = 26'h012_3450;

    logic                               clk_i, reset_i, full_o, empty_o;
    logic                               wr_en_i, wr_is_store_i;
    logic [mshr_pkg::PADDR_WTH-1:0]     wr_paddr_i, miss_addr_o, rpl_addr_o;
    logic [mshr_pkg::SIZE_WTH-1:0]      wr_size_i, rpl_size_o;
    logic [mshr_pkg::ROB_WTH-1:0]       wr_rob_idx_i, rpl_rob_idx_o;
    logic [mshr_pkg::DATA_WTH-1:0]      wr_data_i, rpl_data_o;
    logic                               miss_req_o, miss_ack_i, miss_we_o, miss_done_i;
    logic                               rpl_vld_o, rpl_rdy_i, rpl_is_store_o;

    // Write records indexed by write number
    logic [mshr_pkg::PADDR_WTH-1:0]     rec_addr  [NUM_WRITES];
    logic                               rec_store [NUM_WRITES];
    logic [mshr_pkg::SIZE_WTH-1:0]      rec_size  [NUM_WRITES];
    logic [mshr_pkg::ROB_WTH-1:0]       rec_rob   [NUM_WRITES];
    logic [mshr_pkg::DATA_WTH-1:0]      rec_data  [NUM_WRITES];

    // Reference head FIFO circular over MSHR_LEN slots
    logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] hd_block  [mshr_pkg::MSHR_LEN];
    logic                               hd_issued [mshr_pkg::MSHR_LEN];
    logic                               hd_done   [mshr_pkg::MSHR_LEN];
    logic                               hd_we     [mshr_pkg::MSHR_LEN];
    int unsigned                        hd_cnt    [mshr_pkg::MSHR_LEN];
    int unsigned                        hd_ent    [mshr_pkg::MSHR_LEN][mshr_pkg::MSHR_LEN];
    int unsigned hd_first = 0, hd_num = 0, ent_num = 0, rpl_pos = 0;
    int unsigned sent = 0, wr_id = 0, replayed = 0, cycle_cnt = 0, done_delay = 0;
    logic        del_pending = 1'b0, refill_busy = 1'b0;
    logic [31:0] lfsr_q;

    dcache_mshr dcache_mshr_i (.*);

    bind dcache_mshr dcache_mshr_assertions assertions_i (
        .clk_i(clk_i), .reset_i(reset_i), .full_i(full_o), .empty_i(empty_o),
        .miss_req_i(miss_req_o), .miss_ack_i(miss_ack_i), .miss_addr_i(miss_addr_o),
        .rpl_vld_i(rpl_vld_o), .rpl_rdy_i(rpl_rdy_i), .rpl_addr_i(rpl_addr_o),
        .rpl_is_store_i(rpl_is_store_o), .rpl_size_i(rpl_size_o),
        .rpl_rob_idx_i(rpl_rob_idx_o), .rpl_data_i(rpl_data_o)
    );

    // ==============================
    // Helpers
    // ==============================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int unsigned n, output logic [31:0] v);
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input logic [mshr_pkg::PADDR_WTH-1:0] got, exp, input string what);
        if (got !== exp)
            report_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp)
            report_error($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_size(input logic [mshr_pkg::SIZE_WTH-1:0] got, exp, input string what);
        if (got !== exp)
            report_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_tag(input logic [mshr_pkg::ROB_WTH-1:0] got, exp, input string what);
        if (got !== exp)
            report_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_data(input logic [mshr_pkg::DATA_WTH-1:0] got, exp, input string what);
        if (got !== exp)
            report_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // ==============================
    // Stimulus
    // ==============================

    task automatic drive_inputs();
        logic [31:0] r;
        logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] blk;
        wr_en_i = 1'b0;
        take_bits(1, r);
        if (!full_o && sent < NUM_WRITES && r[0]) begin
            take_bits(3, r);
            blk = BLOCK_BASE + mshr_pkg::BLOCK_ADDR_WTH'(r[2:0]);
            take_bits(mshr_pkg::BLOCK_WTH, r);
            rec_addr[sent] = {blk, r[mshr_pkg::BLOCK_WTH-1:0]};
            take_bits(1, r);
            rec_store[sent] = r[0];
            take_bits(mshr_pkg::SIZE_WTH, r);
            rec_size[sent] = r[mshr_pkg::SIZE_WTH-1:0];
            take_bits(mshr_pkg::ROB_WTH, r);
            rec_rob[sent] = r[mshr_pkg::ROB_WTH-1:0];
            take_bits(mshr_pkg::DATA_WTH, r);
            rec_data[sent] = r;
            wr_paddr_i    = rec_addr[sent];
            wr_is_store_i = rec_store[sent];
            wr_size_i     = rec_size[sent];
            wr_rob_idx_i  = rec_rob[sent];
            wr_data_i     = rec_data[sent];
            wr_en_i       = 1'b1;
            wr_id         = sent;
            sent++;
        end
        // Acknowledge one cycle in four on average
        take_bits(2, r);
        miss_ack_i = r[0] & r[1];
        take_bits(1, r);
        rpl_rdy_i = r[0];
        miss_done_i = 1'b0;
        if (refill_busy) begin
            if (done_delay == 0) begin
                miss_done_i = 1'b1;
                refill_busy = 1'b0;
            end else begin
                done_delay--;
            end
        end
    endtask

    // ==============================
    // Reference model stepped once per clock edge
    // ==============================

    task automatic model_step();
        int unsigned old;
        int unsigned slot;
        int unsigned id;
        logic [31:0] r;
        logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] blk;
        old = hd_first;
        check_flag(full_o, hd_num == mshr_pkg::MSHR_LEN || ent_num == mshr_pkg::MSHR_LEN, "full_o");
        check_flag(empty_o, hd_num == 0 && ent_num == 0, "empty_o");
        if (dcache_mshr_i.assertions_i.fail_cnt != 0)
            report_error("a protocol assertion on the DUT ports failed");
        if (miss_req_o && miss_ack_i) begin
            if (hd_num == 0 || hd_issued[old])
                report_error("refill request accepted with no pending unissued head");
            check_addr(miss_addr_o, {hd_block[old], {mshr_pkg::BLOCK_WTH{1'b0}}}, "miss_addr_o");
            check_flag(miss_we_o, hd_we[old], "miss_we_o");
        end
        if (rpl_vld_o && rpl_rdy_i) begin
            if (hd_num == 0 || !hd_done[old] || del_pending)
                report_error("replay transfer with no completed refill to replay");
            id = hd_ent[old][rpl_pos];
            check_addr(rpl_addr_o, rec_addr[id], "rpl_addr_o");
            check_flag(rpl_is_store_o, rec_store[id], "rpl_is_store_o");
            check_size(rpl_size_o, rec_size[id], "rpl_size_o");
            check_tag(rpl_rob_idx_o, rec_rob[id], "rpl_rob_idx_o");
            check_data(rpl_data_o, rec_data[id], "rpl_data_o");
        end
        if (del_pending)
            check_flag(rpl_vld_o, 1'b0, "rpl_vld_o in the delete cycle");
        // Merge sees the issue flags from before this edge
        if (wr_en_i) begin
            blk  = rec_addr[wr_id][mshr_pkg::PADDR_WTH-1:mshr_pkg::BLOCK_WTH];
            slot = mshr_pkg::MSHR_LEN;
            for (int unsigned k = 0; k < hd_num; k++) begin
                id = (old + k) % mshr_pkg::MSHR_LEN;
                if (!hd_issued[id] && hd_block[id] == blk)
                    slot = id;
            end
            if (slot == mshr_pkg::MSHR_LEN) begin
                slot = (old + hd_num) % mshr_pkg::MSHR_LEN;
                hd_block[slot]  = blk;
                hd_issued[slot] = 1'b0;
                hd_done[slot]   = 1'b0;
                hd_we[slot]     = 1'b0;
                hd_cnt[slot]    = 0;
                hd_num++;
            end
            hd_ent[slot][hd_cnt[slot]] = wr_id;
            hd_cnt[slot]++;
            hd_we[slot] = hd_we[slot] | rec_store[wr_id];
            ent_num++;
        end
        if (miss_req_o && miss_ack_i) begin
            hd_issued[old] = 1'b1;
            refill_busy    = 1'b1;
            take_bits(3, r);
            done_delay = r;
        end
        if (miss_done_i)
            hd_done[old] = 1'b1;
        if (del_pending) begin
            hd_first    = (old + 1) % mshr_pkg::MSHR_LEN;
            hd_num--;
            del_pending = 1'b0;
        end
        if (rpl_vld_o && rpl_rdy_i) begin
            rpl_pos++;
            ent_num--;
            replayed++;
            if (rpl_pos == hd_cnt[old]) begin
                del_pending = 1'b1;
                rpl_pos     = 0;
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES)
            report_error("timeout: the run did not finish within the cycle limit");
    end

    initial begin
        lfsr_q        = SEED;
        reset_i       = 1'b1;
        wr_en_i       = 1'b0;
        wr_paddr_i    = '0;
        wr_is_store_i = 1'b0;
        wr_size_i     = '0;
        wr_rob_idx_i  = '0;
        wr_data_i     = '0;
        miss_ack_i    = 1'b0;
        miss_done_i   = 1'b0;
        rpl_rdy_i     = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // Drive after each edge, check and update the model mid cycle
        while (sent < NUM_WRITES || hd_num != 0 || ent_num != 0) begin
            drive_inputs();
            @(negedge clk_i);
            model_step();
            @(posedge clk_i);
            #1;
        end
        if (replayed == NUM_WRITES && empty_o && dcache_mshr_i.assertions_i.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_error($sformatf("run ended with %0d of %0d writes replayed, empty_o %b",
                                   replayed, NUM_WRITES, empty_o));
        end
    end

endmodule

//--- tests/dcache_mshr_assertions.sv
// Bound into dcache_mshr; covers the refill and replay handshakes and the status flags only

`timescale 1ns/1ps

module dcache_mshr_assertions (
    input logic                             clk_i,
    input logic                             reset_i,
    input logic                             full_i,
    input logic                             empty_i,
    input logic                             miss_req_i,
    input logic                             miss_ack_i,
    input logic [mshr_pkg::PADDR_WTH-1:0]   miss_addr_i,
    input logic                             rpl_vld_i,
    input logic                             rpl_rdy_i,
    input logic [mshr_pkg::PADDR_WTH-1:0]   rpl_addr_i,
    input logic                             rpl_is_store_i,
    input logic [mshr_pkg::SIZE_WTH-1:0]    rpl_size_i,
    input logic [mshr_pkg::ROB_WTH-1:0]     rpl_rob_idx_i,
    input logic [mshr_pkg::DATA_WTH-1:0]    rpl_data_i
);

    // Failures seen so far
    int unsigned fail_cnt = 0;

    // Request level holds its address until acknowledged
    req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        miss_req_i && !miss_ack_i |=> miss_req_i && $stable(miss_addr_i))
        else begin
            $error("refill request dropped or moved before acknowledge");
            fail_cnt++;
        end

    rpl_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        rpl_vld_i && !rpl_rdy_i |=> rpl_vld_i && $stable(rpl_addr_i)
            && $stable(rpl_is_store_i) && $stable(rpl_size_i)
            && $stable(rpl_rob_idx_i) && $stable(rpl_data_i))
        else begin
            $error("replay dropped or changed while stalled");
            fail_cnt++;
        end

    // No request or replay while both tables are empty
    empty_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        empty_i |-> !miss_req_i && !rpl_vld_i)
        else begin
            $error("request or replay active while empty");
            fail_cnt++;
        end

    // Quiet and empty right after reset
    reset_state: assert property (@(posedge clk_i)
        reset_i |=> !miss_req_i && !rpl_vld_i && empty_i && !full_i)
        else begin
            $error("outputs not idle after reset");
            fail_cnt++;
        end

endmodule

//--- logic/dcache_mshr.sv
// wr_en_i is only legal while full_o is low; one refill is outstanding at a time

`timescale 1ns/1ps

module dcache_mshr (
    input  logic                                clk_i,
    input  logic                                reset_i,
    output logic                                full_o,
    output logic                                empty_o,
    // Miss from the cache controller
    input  logic                                wr_en_i,
    input  logic [mshr_pkg::PADDR_WTH-1:0]      wr_paddr_i,
    input  logic                                wr_is_store_i,
    input  logic [mshr_pkg::SIZE_WTH-1:0]       wr_size_i,
    input  logic [mshr_pkg::ROB_WTH-1:0]        wr_rob_idx_i,
    input  logic [mshr_pkg::DATA_WTH-1:0]       wr_data_i,
    // Refill request
    output logic                                miss_req_o,
    input  logic                                miss_ack_i,
    output logic [mshr_pkg::PADDR_WTH-1:0]      miss_addr_o,
    output logic                                miss_we_o,
    input  logic                                miss_done_i,
    // Replay
    output logic                                rpl_vld_o,
    input  logic                                rpl_rdy_i,
    output logic [mshr_pkg::PADDR_WTH-1:0]      rpl_addr_o,
    output logic                                rpl_is_store_o,
    output logic [mshr_pkg::SIZE_WTH-1:0]       rpl_size_o,
    output logic [mshr_pkg::ROB_WTH-1:0]        rpl_rob_idx_o,
    output logic [mshr_pkg::DATA_WTH-1:0]       rpl_data_o
);

    logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] wr_block, head_block;
    logic [mshr_pkg::BLOCK_WTH-1:0]      wr_offset, rd_offset;
    logic [mshr_pkg::MSHR_WTH-1:0]       alloc_idx, rd_idx, rel_idx, sel_loc, sel_pos;
    logic [mshr_pkg::MSHR_WTH:0]         entry_cnt, head_cnt, head_num;
    logic                                rd_is_store, rel, head_vld, head_we, issue, del;
    logic [mshr_pkg::SIZE_WTH-1:0]       rd_size;
    logic [mshr_pkg::ROB_WTH-1:0]        rd_rob_idx;
    logic [mshr_pkg::DATA_WTH-1:0]       rd_data;

    assign wr_block  = wr_paddr_i[mshr_pkg::PADDR_WTH-1:mshr_pkg::BLOCK_WTH];
    assign wr_offset = wr_paddr_i[mshr_pkg::BLOCK_WTH-1:0];

    // Either table running out blocks new misses
    assign full_o  = (head_num == (mshr_pkg::MSHR_WTH + 1)'(mshr_pkg::MSHR_LEN))
                  || (entry_cnt == (mshr_pkg::MSHR_WTH + 1)'(mshr_pkg::MSHR_LEN));
    assign empty_o = (head_num == '0) && (entry_cnt == '0);

    mshr_entry_pool entry_pool_i (
        .clk_i, .reset_i, .wr_en_i, .wr_is_store_i, .wr_size_i, .wr_rob_idx_i, .wr_data_i,
        .wr_offset_i(wr_offset), .alloc_idx_o(alloc_idx), .rd_idx_i(rd_idx),
        .rd_is_store_o(rd_is_store), .rd_size_o(rd_size), .rd_offset_o(rd_offset),
        .rd_rob_idx_o(rd_rob_idx), .rd_data_o(rd_data), .rel_i(rel), .rel_idx_i(rel_idx),
        .entry_cnt_o(entry_cnt)
    );

    mshr_head_table head_table_i (
        .clk_i, .reset_i, .wr_en_i, .wr_block_i(wr_block), .wr_is_store_i,
        .alloc_idx_i(alloc_idx), .issue_i(issue), .del_i(del), .sel_pos_i(sel_pos),
        .head_vld_o(head_vld), .head_block_o(head_block), .head_we_o(head_we),
        .head_cnt_o(head_cnt), .sel_loc_o(sel_loc), .head_num_o(head_num)
    );

    mshr_ctrl ctrl_i (
        .clk_i, .reset_i, .head_vld_i(head_vld), .head_block_i(head_block),
        .head_we_i(head_we), .head_cnt_i(head_cnt), .sel_loc_i(sel_loc),
        .issue_o(issue), .del_o(del), .sel_pos_o(sel_pos),
        .rd_offset_i(rd_offset), .rd_is_store_i(rd_is_store), .rd_size_i(rd_size),
        .rd_rob_idx_i(rd_rob_idx), .rd_data_i(rd_data), .rd_idx_o(rd_idx),
        .rel_o(rel), .rel_idx_o(rel_idx),
        .miss_req_o, .miss_ack_i, .miss_addr_o, .miss_we_o, .miss_done_i,
        .rpl_vld_o, .rpl_rdy_i, .rpl_addr_o, .rpl_is_store_o, .rpl_size_o,
        .rpl_rob_idx_o, .rpl_data_o
    );

endmodule

//--- logic/mshr_ctrl.sv
// Serves one head at a time; miss_done_i is only expected after an accepted request

`timescale 1ns/1ps

module mshr_ctrl (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    // Oldest head from the head table
    input  logic                                 head_vld_i,
    input  logic [mshr_pkg::BLOCK_ADDR_WTH-1:0]  head_block_i,
    input  logic                                 head_we_i,
    input  logic [mshr_pkg::MSHR_WTH:0]          head_cnt_i,
    input  logic [mshr_pkg::MSHR_WTH-1:0]        sel_loc_i,
    output logic                                 issue_o,
    output logic                                 del_o,
    output logic [mshr_pkg::MSHR_WTH-1:0]        sel_pos_o,
    // Entry pool access
    input  logic [mshr_pkg::BLOCK_WTH-1:0]       rd_offset_i,
    input  logic                                 rd_is_store_i,
    input  logic [mshr_pkg::SIZE_WTH-1:0]        rd_size_i,
    input  logic [mshr_pkg::ROB_WTH-1:0]         rd_rob_idx_i,
    input  logic [mshr_pkg::DATA_WTH-1:0]        rd_data_i,
    output logic [mshr_pkg::MSHR_WTH-1:0]        rd_idx_o,
    output logic                                 rel_o,
    output logic [mshr_pkg::MSHR_WTH-1:0]        rel_idx_o,
    // Refill request
    output logic                                 miss_req_o,
    input  logic                                 miss_ack_i,
    output logic [mshr_pkg::PADDR_WTH-1:0]       miss_addr_o,
    output logic                                 miss_we_o,
    input  logic                                 miss_done_i,
    // Replay to the cache
    output logic                                 rpl_vld_o,
    input  logic                                 rpl_rdy_i,
    output logic [mshr_pkg::PADDR_WTH-1:0]       rpl_addr_o,
    output logic                                 rpl_is_store_o,
    output logic [mshr_pkg::SIZE_WTH-1:0]        rpl_size_o,
    output logic [mshr_pkg::ROB_WTH-1:0]         rpl_rob_idx_o,
    output logic [mshr_pkg::DATA_WTH-1:0]        rpl_data_o
);

    logic [1:0]                    state_q, state_d;
    // Entries of the current head already replayed
    logic [mshr_pkg::MSHR_WTH:0]   pos_q, pos_d;
    logic [mshr_pkg::MSHR_WTH-1:0] rpl_idx_q, rpl_idx_d;
    logic                          rpl_done;

    assign rpl_done = (pos_q == head_cnt_i);

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_d    = state_q;
        pos_d      = pos_q;
        rpl_idx_d  = rpl_idx_q;
        sel_pos_o  = '0;
        miss_req_o = 1'b0;
        issue_o    = 1'b0;
        rpl_vld_o  = 1'b0;
        rel_o      = 1'b0;
        del_o      = 1'b0;
        case (state_q)
            mshr_pkg::ST_IDLE: begin
                if (head_vld_i) begin
                    state_d = mshr_pkg::ST_REFILL_REQ;
                end
            end
            mshr_pkg::ST_REFILL_REQ: begin
                miss_req_o = 1'b1;
                if (miss_ack_i) begin
                    issue_o = 1'b1;
                    state_d = mshr_pkg::ST_REFILL_WAIT;
                end
            end
            mshr_pkg::ST_REFILL_WAIT: begin
                // Load the first entry of the list for replay
                if (miss_done_i) begin
                    pos_d     = '0;
                    rpl_idx_d = sel_loc_i;
                    state_d   = mshr_pkg::ST_REPLAY_REQ;
                end
            end
            mshr_pkg::ST_REPLAY_REQ: begin
                if (rpl_done) begin
                    // Idle cycle that frees the head
                    del_o   = 1'b1;
                    state_d = mshr_pkg::ST_IDLE;
                end else begin
                    rpl_vld_o = 1'b1;
                    sel_pos_o = pos_q[mshr_pkg::MSHR_WTH-1:0] + 1'b1;
                    if (rpl_rdy_i) begin
                        rel_o     = 1'b1;
                        pos_d     = pos_q + 1'b1;
                        rpl_idx_d = sel_loc_i;
                    end
                end
            end
            default: begin
                state_d = mshr_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= mshr_pkg::ST_IDLE;
            pos_q   <= '0;
        end else begin
            state_q <= state_d;
            pos_q   <= pos_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rpl_idx_q <= rpl_idx_d;
    end

    // ==============================
    // Request and replay fields
    // ==============================

    assign miss_addr_o    = {head_block_i, {mshr_pkg::BLOCK_WTH{1'b0}}};
    assign miss_we_o      = head_we_i;

    assign rd_idx_o       = rpl_idx_q;
    assign rel_idx_o      = rpl_idx_q;
    assign rpl_addr_o     = {head_block_i, rd_offset_i};
    assign rpl_is_store_o = rd_is_store_i;
    assign rpl_size_o     = rd_size_i;
    assign rpl_rob_idx_o  = rd_rob_idx_i;
    assign rpl_data_o     = rd_data_i;

endmodule

//--- logic/mshr_head_table.sv
// Heads leave strictly in order; issue and delete always act on the oldest head

`timescale 1ns/1ps

module mshr_head_table (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    // New miss from the cache controller
    input  logic                                 wr_en_i,
    input  logic [mshr_pkg::BLOCK_ADDR_WTH-1:0]  wr_block_i,
    input  logic                                 wr_is_store_i,
    input  logic [mshr_pkg::MSHR_WTH-1:0]        alloc_idx_i,
    // From the controller
    input  logic                                 issue_i,
    input  logic                                 del_i,
    input  logic [mshr_pkg::MSHR_WTH-1:0]        sel_pos_i,
    // Oldest head view
    output logic                                 head_vld_o,
    output logic [mshr_pkg::BLOCK_ADDR_WTH-1:0]  head_block_o,
    output logic                                 head_we_o,
    output logic [mshr_pkg::MSHR_WTH:0]          head_cnt_o,
    output logic [mshr_pkg::MSHR_WTH-1:0]        sel_loc_o,
    output logic [mshr_pkg::MSHR_WTH:0]          head_num_o
);

    logic [mshr_pkg::MSHR_LEN-1:0]       vld_q;
    logic [mshr_pkg::MSHR_LEN-1:0]       issued_q;
    logic [mshr_pkg::MSHR_WTH-1:0]       ins_ptr_q;
    logic [mshr_pkg::MSHR_WTH-1:0]       del_ptr_q;
    logic [mshr_pkg::MSHR_WTH:0]         num_q;

    logic [mshr_pkg::BLOCK_ADDR_WTH-1:0] block_q [mshr_pkg::MSHR_LEN];
    logic                                we_q    [mshr_pkg::MSHR_LEN];
    logic [mshr_pkg::MSHR_WTH:0]         cnt_q   [mshr_pkg::MSHR_LEN];
    // Entry locations per head in write order
    logic [mshr_pkg::MSHR_WTH-1:0]       loc_q   [mshr_pkg::MSHR_LEN][mshr_pkg::MSHR_LEN];

    logic                                merge_hit;
    logic [mshr_pkg::MSHR_WTH-1:0]       merge_sel;
    logic                                merge_en;
    logic                                alloc_en;
    logic [mshr_pkg::MSHR_WTH-1:0]       merge_pos;

    // ==============================
    // Block match
    // ==============================

    // Only unissued heads accept merges and at most one can match
    always_comb begin
        merge_hit = 1'b0;
        merge_sel = '0;
        for (int i = 0; i < mshr_pkg::MSHR_LEN; i++) begin
            if (vld_q[i] && !issued_q[i] && block_q[i] == wr_block_i) begin
                merge_hit = 1'b1;
                merge_sel = mshr_pkg::MSHR_WTH'(i);
            end
        end
    end

    assign merge_en  = wr_en_i && merge_hit;
    assign alloc_en  = wr_en_i && !merge_hit;
    // Next free slot of the matched head's list
    assign merge_pos = cnt_q[merge_sel][mshr_pkg::MSHR_WTH-1:0];

    // ==============================
    // Control state
    // ==============================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vld_q     <= '0;
            issued_q  <= '0;
            ins_ptr_q <= '0;
            del_ptr_q <= '0;
            num_q     <= '0;
        end else begin
            if (alloc_en) begin
                vld_q[ins_ptr_q]    <= 1'b1;
                issued_q[ins_ptr_q] <= 1'b0;
                ins_ptr_q           <= ins_ptr_q + 1'b1;
            end
            if (issue_i) begin
                issued_q[del_ptr_q] <= 1'b1;
            end
            if (del_i) begin
                vld_q[del_ptr_q] <= 1'b0;
                del_ptr_q        <= del_ptr_q + 1'b1;
            end
            if (alloc_en && !del_i) begin
                num_q <= num_q + 1'b1;
            end else if (!alloc_en && del_i) begin
                num_q <= num_q - 1'b1;
            end
        end
    end

    // ==============================
    // Head payload
    // ==============================

    always_ff @(posedge clk_i) begin
        if (alloc_en) begin
            block_q[ins_ptr_q]   <= wr_block_i;
            we_q[ins_ptr_q]      <= wr_is_store_i;
            cnt_q[ins_ptr_q]     <= (mshr_pkg::MSHR_WTH + 1)'(1);
            loc_q[ins_ptr_q][0]  <= alloc_idx_i;
        end else if (merge_en) begin
            loc_q[merge_sel][merge_pos] <= alloc_idx_i;
            cnt_q[merge_sel]            <= cnt_q[merge_sel] + 1'b1;
            // Any store in the list makes the refill a write
            we_q[merge_sel]             <= we_q[merge_sel] | wr_is_store_i;
        end
    end

    assign head_vld_o   = vld_q[del_ptr_q];
    assign head_block_o = block_q[del_ptr_q];
    assign head_we_o    = we_q[del_ptr_q];
    assign head_cnt_o   = cnt_q[del_ptr_q];
    assign sel_loc_o    = loc_q[del_ptr_q][sel_pos_i];
    assign head_num_o   = num_q;

endmodule

//--- logic/mshr_entry_pool.sv
// Writer must not write while the pool is full; release must name a valid slot

`timescale 1ns/1ps

module mshr_entry_pool (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // Write side
    input  logic                                wr_en_i,
    input  logic                                wr_is_store_i,
    input  logic [mshr_pkg::SIZE_WTH-1:0]       wr_size_i,
    input  logic [mshr_pkg::ROB_WTH-1:0]        wr_rob_idx_i,
    input  logic [mshr_pkg::DATA_WTH-1:0]       wr_data_i,
    input  logic [mshr_pkg::BLOCK_WTH-1:0]      wr_offset_i,
    output logic [mshr_pkg::MSHR_WTH-1:0]       alloc_idx_o,
    // Read and release side
    input  logic [mshr_pkg::MSHR_WTH-1:0]       rd_idx_i,
    output logic                                rd_is_store_o,
    output logic [mshr_pkg::SIZE_WTH-1:0]       rd_size_o,
    output logic [mshr_pkg::BLOCK_WTH-1:0]      rd_offset_o,
    output logic [mshr_pkg::ROB_WTH-1:0]        rd_rob_idx_o,
    output logic [mshr_pkg::DATA_WTH-1:0]       rd_data_o,
    input  logic                                rel_i,
    input  logic [mshr_pkg::MSHR_WTH-1:0]       rel_idx_i,
    output logic [mshr_pkg::MSHR_WTH:0]         entry_cnt_o
);

    logic [mshr_pkg::MSHR_LEN-1:0]  vld_q;
    logic [mshr_pkg::MSHR_WTH:0]    cnt_q;

    logic                           is_store_q [mshr_pkg::MSHR_LEN];
    logic [mshr_pkg::SIZE_WTH-1:0]  size_q     [mshr_pkg::MSHR_LEN];
    logic [mshr_pkg::BLOCK_WTH-1:0] offset_q   [mshr_pkg::MSHR_LEN];
    logic [mshr_pkg::ROB_WTH-1:0]   rob_idx_q  [mshr_pkg::MSHR_LEN];
    logic [mshr_pkg::DATA_WTH-1:0]  data_q     [mshr_pkg::MSHR_LEN];

    // ==============================
    // Free slot search
    // ==============================

    // Last free slot wins, so the highest index is picked
    always_comb begin
        alloc_idx_o = '0;
        for (int i = 0; i < mshr_pkg::MSHR_LEN; i++) begin
            if (!vld_q[i]) begin
                alloc_idx_o = mshr_pkg::MSHR_WTH'(i);
            end
        end
    end

    // ==============================
    // Valid bits and count
    // ==============================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vld_q <= '0;
            cnt_q <= '0;
        end else begin
            if (wr_en_i) begin
                vld_q[alloc_idx_o] <= 1'b1;
            end
            if (rel_i) begin
                vld_q[rel_idx_i] <= 1'b0;
            end
            // Write and release together leave the count alone
            if (wr_en_i && !rel_i) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (!wr_en_i && rel_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            is_store_q[alloc_idx_o] <= wr_is_store_i;
            size_q[alloc_idx_o]     <= wr_size_i;
            offset_q[alloc_idx_o]   <= wr_offset_i;
            rob_idx_q[alloc_idx_o]  <= wr_rob_idx_i;
            data_q[alloc_idx_o]     <= wr_data_i;
        end
    end

    assign rd_is_store_o = is_store_q[rd_idx_i];
    assign rd_size_o     = size_q[rd_idx_i];
    assign rd_offset_o   = offset_q[rd_idx_i];
    assign rd_rob_idx_o  = rob_idx_q[rd_idx_i];
    assign rd_data_o     = data_q[rd_idx_i];
    assign entry_cnt_o   = cnt_q;

endmodule

//--- logic/mshr_pkg.sv
// Fixed for 4 heads and 4 entries, 64-byte blocks and 32-bit physical addresses

package mshr_pkg;

    // ==============================
    // MSHR sizes
    // ==============================

    // Heads and entries share one depth
    localparam int unsigned MSHR_LEN = 4;
    // Counts carry one bit more than an index
    localparam int unsigned MSHR_WTH = 2;

    // ==============================
    // Address fields
    // ==============================

    localparam int unsigned PADDR_WTH      = 32;
    // 64-byte cache block
    localparam int unsigned BLOCK_WTH      = 6;
    localparam int unsigned BLOCK_ADDR_WTH = PADDR_WTH - BLOCK_WTH;

    // ==============================
    // Entry payload
    // ==============================

    localparam int unsigned SIZE_WTH = 2;
    localparam int unsigned ROB_WTH  = 5;
    localparam int unsigned DATA_WTH = 32;

    // Controller state codes
    localparam logic [1:0] ST_IDLE        = 2'd0;
    localparam logic [1:0] ST_REFILL_REQ  = 2'd1;
    localparam logic [1:0] ST_REFILL_WAIT = 2'd2;
    localparam logic [1:0] ST_REPLAY_REQ  = 2'd3;

endpackage
